//--- mem_stage.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/access_check.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/mem_stage.sv
test/mem_stage_sva.sv
test/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# build and run the mem_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_stage \
    -f mem_stage.f --Mdir obj_dir -o sim_mem_stage

# the simulation status is decided by the pass message below
out=$(./obj_dir/sim_mem_stage +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

//--- test/tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module tb_mem_stage;

    localparam int WIN_WORDS  = 8;     // small window so accesses collide
    localparam int N_RANDOM   = 3000;
    localparam int RUN_CYCLES = 2 + WIN_WORDS + N_RANDOM + WIN_WORDS + 4;
    localparam int MEM_BYTES  = 4 * `MEM_DEPTH_WORDS;

    logic                      clk;
    logic                      rst_n;
    mem_stage_pkg::mem_req_t   req0;
    mem_stage_pkg::mem_req_t   req1;
    logic                      mem_sel;
    mem_stage_pkg::mem_exc_t   exc0;
    mem_stage_pkg::mem_exc_t   exc1;
    mem_stage_pkg::load_resp_t load_resp;

    logic [7:0]                model_mem [MEM_BYTES];  // byte view of the ram
    mem_stage_pkg::load_resp_t exp_q [$];              // response due next cycle
    string                     name_q [$];
    int unsigned               n_checks;
    int unsigned               n_errors;

    mem_stage dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req0      (req0),
        .req1      (req1),
        .mem_sel   (mem_sel),
        .exc0      (exc0),
        .exc1      (exc1),
        .load_resp (load_resp)
    );

    bind mem_stage mem_stage_sva u_sva (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_sel    (mem_sel),
        .exc0       (exc0),
        .exc1       (exc1),
        .sel_access (sel_access),
        .wr_en      (wr_en),
        .wr_be      (wr_be),
        .load_resp  (load_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * 10 + 200);
        $display("watchdog timeout: stimulus did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic is_ld(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU: return 1'b1;
            `OP_LW, `OP_LWL, `OP_LWR, `OP_LL: return 1'b1;
            default:                          return 1'b0;
        endcase
    endfunction

    function automatic logic is_st(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_SB, `OP_SH, `OP_SW, `OP_SWL, `OP_SWR, `OP_SC: return 1'b1;
            default:                                          return 1'b0;
        endcase
    endfunction

    // byte boundary an access must sit on
    function automatic int align_need(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_LW, `OP_LL, `OP_SW, `OP_SC: return 4;
            `OP_LH, `OP_LHU, `OP_SH:        return 2;
            default:                        return 1;
        endcase
    endfunction

    function automatic logic misaligned(input mem_stage_pkg::opcode_t op,
                                        input mem_stage_pkg::addr_t   addr);
        return (int'(addr[1:0]) % align_need(op)) != 0;
    endfunction

    function automatic mem_stage_pkg::mem_exc_t exp_exc(input mem_stage_pkg::mem_req_t r);
        mem_stage_pkg::mem_exc_t e;
        e.load_err  = r.valid && is_ld(r.op) && misaligned(r.op, r.addr);
        e.store_err = r.valid && is_st(r.op) && misaligned(r.op, r.addr);
        return e;
    endfunction

    function automatic void model_store(input mem_stage_pkg::opcode_t op,
                                        input mem_stage_pkg::addr_t   addr,
                                        input mem_stage_pkg::word_t   data);
        int base;
        int off;
        base = 4 * int'(addr[`MEM_IDX_W+1:2]);
        off  = int'(addr[1:0]);
        case (op)
            `OP_SW, `OP_SC: begin
                for (int i = 0; i < 4; i++) begin
                    model_mem[base+i] = data[8*i +: 8];
                end
            end
            `OP_SH: begin
                model_mem[base+off]   = data[7:0];
                model_mem[base+off+1] = data[15:8];
            end
            `OP_SB: model_mem[base+off] = data[7:0];
            `OP_SWL: begin
                for (int i = 0; i <= off; i++) begin
                    model_mem[base+i] = data[8*(3-off+i) +: 8];  // top bytes first
                end
            end
            `OP_SWR: begin
                for (int i = off; i < 4; i++) begin
                    model_mem[base+i] = data[8*(i-off) +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    function automatic mem_stage_pkg::word_t model_load(input mem_stage_pkg::opcode_t op,
                                                        input mem_stage_pkg::addr_t   addr,
                                                        input mem_stage_pkg::word_t   rt);
        mem_stage_pkg::word_t w;
        mem_stage_pkg::word_t res;
        logic [7:0]           b;
        logic [15:0]          h;
        int                   base;
        int                   off;
        base = 4 * int'(addr[`MEM_IDX_W+1:2]);
        off  = int'(addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model_mem[base+i];
        end
        b   = w[8*off +: 8];
        h   = (off >= 2) ? w[31:16] : w[15:0];
        res = w;
        case (op)
            `OP_LB:  res = {{24{b[7]}}, b};
            `OP_LBU: res = {24'h000000, b};
            `OP_LH:  res = {{16{h[15]}}, h};
            `OP_LHU: res = {16'h0000, h};
            `OP_LWL: begin
                for (int j = 0; j < 4; j++) begin
                    if (j >= 3 - off) begin
                        res[8*j +: 8] = w[8*(j-3+off) +: 8];
                    end else begin
                        res[8*j +: 8] = rt[8*j +: 8];
                    end
                end
            end
            `OP_LWR: begin
                for (int j = 0; j < 4; j++) begin
                    if (j <= 3 - off) begin
                        res[8*j +: 8] = w[8*(j+off) +: 8];
                    end else begin
                        res[8*j +: 8] = rt[8*j +: 8];
                    end
                end
            end
            default: res = w;
        endcase
        return res;
    endfunction

    function automatic mem_stage_pkg::opcode_t op_from_index(input int k);
        case (k)
            0:       return `OP_LB;
            1:       return `OP_LH;
            2:       return `OP_LWL;
            3:       return `OP_LW;
            4:       return `OP_LBU;
            5:       return `OP_LHU;
            6:       return `OP_LWR;
            7:       return `OP_SB;
            8:       return `OP_SH;
            9:       return `OP_SWL;
            10:      return `OP_SW;
            11:      return `OP_SWR;
            12:      return `OP_LL;
            13:      return `OP_SC;
            14:      return 6'h00;  // special
            15:      return 6'h04;  // beq
            16:      return 6'h09;  // addiu
            default: return 6'h0f;  // lui
        endcase
    endfunction

    function automatic string test_for(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU: return "load_extend";
            `OP_LWL, `OP_LWR:                 return "unaligned_merge";
            `OP_LW, `OP_LL:                   return "word_load";
            default:                          return "no_response";
        endcase
    endfunction

    function automatic mem_stage_pkg::mem_req_t rand_req();
        mem_stage_pkg::mem_req_t r;
        r.valid    = ($urandom_range(0, 7) != 0);
        r.op       = op_from_index($urandom_range(0, 17));
        r.addr     = $urandom_range(0, 4 * WIN_WORDS - 1);
        r.wdata    = $urandom;
        r.rt_value = $urandom;
        if ($urandom_range(0, 1) == 1) begin  // half of them aligned on purpose
            if (align_need(r.op) == 4) begin
                r.addr[1:0] = 2'b00;
            end else if (align_need(r.op) == 2) begin
                r.addr[0] = 1'b0;
            end
        end
        return r;
    endfunction

    // drive one cycle and advance the model by the selected access
    task automatic issue(input mem_stage_pkg::mem_req_t r0, input mem_stage_pkg::mem_req_t r1,
                         input logic sel, input string tag);
        mem_stage_pkg::mem_req_t   s;
        mem_stage_pkg::load_resp_t e;
        logic                      ok;
        req0    = r0;
        req1    = r1;
        mem_sel = sel;
        s  = sel ? r0 : r1;
        ok = s.valid && (is_ld(s.op) || is_st(s.op)) && !misaligned(s.op, s.addr);
        e  = '0;
        e.valid = ok && is_ld(s.op);
        if (e.valid) begin
            e.data = model_load(s.op, s.addr, s.rt_value);
        end
        if (ok && is_st(s.op)) begin
            model_store(s.op, s.addr, s.wdata);
        end
        exp_q.push_back(e);
        if (tag.len() == 0) begin
            name_q.push_back(test_for(s.op));
        end else begin
            name_q.push_back(tag);
        end
    endtask

    task automatic check_cycle();
        mem_stage_pkg::mem_exc_t   e0;
        mem_stage_pkg::mem_exc_t   e1;
        mem_stage_pkg::load_resp_t e;
        string                     name;
        e0 = exp_exc(req0);
        e1 = exp_exc(req1);
        n_checks += 2;
        assert (exc0 == e0) else begin
            n_errors++;
            $display("** Error [alignment_lane0] expected %b, actual %b", e0, exc0);
        end
        assert (exc1 == e1) else begin
            n_errors++;
            $display("** Error [alignment_lane1] expected %b, actual %b", e1, exc1);
        end
        if (exp_q.size() > 0) begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            n_checks++;
            assert (load_resp.valid == e.valid) else begin
                n_errors++;
                $display("** Error [%s valid] expected %0b, actual %0b",
                         name, e.valid, load_resp.valid);
            end
            if (e.valid) begin
                n_checks++;
                assert (load_resp.data == e.data) else begin
                    n_errors++;
                    $display("** Error [%s data] expected %h, actual %h",
                             name, e.data, load_resp.data);
                end
            end
        end
    endtask

    initial begin
        mem_stage_pkg::mem_req_t r0;
        mem_stage_pkg::mem_req_t r1;
        mem_stage_pkg::mem_req_t idle;
        void'($urandom(32'h5e07));
        n_checks = 0;
        n_errors = 0;
        idle     = '0;
        req0     = '0;
        req1     = '0;
        mem_sel  = 1'b0;
        rst_n    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // preload the window with aligned word stores
        for (int w = 0; w < WIN_WORDS; w++) begin
            check_cycle();
            r0       = idle;
            r0.valid = 1'b1;
            r0.op    = `OP_SW;
            r0.addr  = 4 * w;
            r0.wdata = $urandom;
            issue(r0, idle, 1'b1, "preload");
            @(negedge clk);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            check_cycle();
            r0 = rand_req();
            r1 = rand_req();
            issue(r0, r1, ($urandom_range(0, 1) == 1), "");
            @(negedge clk);
        end

        // word readback on lane 1, lane 0 keeps random traffic
        for (int w = 0; w < WIN_WORDS; w++) begin
            check_cycle();
            r0          = rand_req();
            r1          = idle;
            r1.valid    = 1'b1;
            r1.op       = `OP_LW;
            r1.addr     = 4 * w;
            r1.rt_value = $urandom;
            issue(r0, r1, 1'b0, "store_readback");
            @(negedge clk);
        end
        check_cycle();

        n_errors = n_errors + dut0.u_sva.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, dut0.u_sva.fail_count);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/mem_stage_sva.sv
`timescale 1ns/1ps

module mem_stage_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       mem_sel,
    input mem_stage_pkg::mem_exc_t    exc0,
    input mem_stage_pkg::mem_exc_t    exc1,
    input mem_stage_pkg::mem_access_t sel_access,
    input logic                       wr_en,
    input mem_stage_pkg::byte_en_t    wr_be,
    input mem_stage_pkg::load_resp_t  load_resp
);

    int unsigned fail_count;
    logic        ld_issue;
    logic        sel_err;

    initial fail_count = 0;

    assign ld_issue = sel_access.valid & sel_access.is_load;
    assign sel_err  = mem_sel ? (exc0.load_err | exc0.store_err)
                              : (exc1.load_err | exc1.store_err);

    // M2 response strobe tracks the M read by one cycle
    resp_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        ld_issue |=> load_resp.valid)
    else begin
        $error("no load response one cycle after a selected load");
        fail_count++;
    end

    resp_only_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        !ld_issue |=> !load_resp.valid)
    else begin
        $error("load response without a selected load in the previous cycle");
        fail_count++;
    end

    be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_be != 4'b0000))
    else begin
        $error("write enabled with an empty byte mask");
        fail_count++;
    end

    no_write_on_err: assert property (@(posedge clk) disable iff (!rst_n)
        sel_err |-> !wr_en)
    else begin
        $error("memory written while the selected lane flags an alignment error");
        fail_count++;
    end

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module mem_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_stage_pkg::mem_req_t   req0,
    input  mem_stage_pkg::mem_req_t   req1,
    input  logic                      mem_sel,
    output mem_stage_pkg::mem_exc_t   exc0,
    output mem_stage_pkg::mem_exc_t   exc1,
    output mem_stage_pkg::load_resp_t load_resp
);

    mem_stage_pkg::mem_access_t sel_access;

    // write port
    logic                    wr_en;
    logic [`MEM_IDX_W-1:0]   wr_idx;
    mem_stage_pkg::byte_en_t wr_be;
    mem_stage_pkg::word_t    wr_data;

    // read port
    logic                    rd_en;
    logic [`MEM_IDX_W-1:0]   rd_idx;
    mem_stage_pkg::word_t    rd_data;

    access_check u_access_check (
        .req0       (req0),
        .req1       (req1),
        .mem_sel    (mem_sel),
        .exc0       (exc0),
        .exc1       (exc1),
        .sel_access (sel_access)
    );

    store_align u_store_align (
        .sel_access (sel_access),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_be      (wr_be),
        .wr_data    (wr_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_be   (wr_be),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    load_align u_load_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel_access (sel_access),
        .rd_en      (rd_en),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data),
        .load_resp  (load_resp)
    );

endmodule

//--- hdl/load_align.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module load_align (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_stage_pkg::mem_access_t sel_access,
    output logic                       rd_en,
    output logic [`MEM_IDX_W-1:0]      rd_idx,
    input  mem_stage_pkg::word_t       rd_data,
    output mem_stage_pkg::load_resp_t  load_resp
);

    // M2 holding register, payload part
    typedef struct packed {
        mem_stage_pkg::opcode_t op;
        logic [1:0]             off;
        mem_stage_pkg::word_t   rt;
    } m2_info_t;

    logic                 m2_valid;
    m2_info_t             m2;
    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;
    mem_stage_pkg::word_t keep_mask;
    mem_stage_pkg::word_t ld_data;

    assign rd_en  = sel_access.valid & sel_access.is_load;
    assign rd_idx = sel_access.addr[`MEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid <= 1'b0;
        end else begin
            m2_valid <= rd_en;  // one-cycle response strobe
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            m2.op  <= sel_access.op;
            m2.off <= sel_access.addr[1:0];
            m2.rt  <= sel_access.rt_value;
        end
    end

    assign sel_byte = rd_data[{m2.off, 3'b000} +: 8];
    assign sel_half = rd_data[{m2.off[1], 4'b0000} +: 16];

    always_comb begin
        keep_mask = '0;
        ld_data   = rd_data;
        case (m2.op)
            `OP_LB:  ld_data = {{24{sel_byte[7]}}, sel_byte};
            `OP_LBU: ld_data = {24'h000000, sel_byte};
            `OP_LH:  ld_data = {{16{sel_half[15]}}, sel_half};
            `OP_LHU: ld_data = {16'h0000, sel_half};
            `OP_LW, `OP_LL: ld_data = rd_data;
            // low memory bytes go to the top, rt fills the rest
            `OP_LWL: begin
                keep_mask = 32'h00ff_ffff >> {m2.off, 3'b000};
                ld_data   = (rd_data << {~m2.off, 3'b000}) | (m2.rt & keep_mask);
            end
            // high memory bytes shifted down, rt keeps the top
            `OP_LWR: begin
                keep_mask = ~(32'hffff_ffff >> {m2.off, 3'b000});
                ld_data   = (rd_data >> {m2.off, 3'b000}) | (m2.rt & keep_mask);
            end
            default: begin
                keep_mask = '0;
                ld_data   = rd_data;
            end
        endcase
    end

    assign load_resp.valid = m2_valid;
    assign load_resp.data  = ld_data;

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module data_ram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`MEM_IDX_W-1:0]   wr_idx,
    input  mem_stage_pkg::byte_en_t wr_be,
    input  mem_stage_pkg::word_t    wr_data,
    input  logic                    rd_en,
    input  logic [`MEM_IDX_W-1:0]   rd_idx,
    output mem_stage_pkg::word_t    rd_data
);

    mem_stage_pkg::word_t mem [`MEM_DEPTH_WORDS];
    mem_stage_pkg::word_t rd_word;

    // write-first view of the addressed word
    always_comb begin
        rd_word = mem[rd_idx];
        for (int b = 0; b < 4; b++) begin
            if (wr_en && wr_be[b] && (wr_idx == rd_idx)) begin
                rd_word[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if (rd_en) begin
            rd_data <= rd_word;
        end
    end

endmodule

//--- hdl/store_align.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module store_align (
    input  mem_stage_pkg::mem_access_t sel_access,
    output logic                       wr_en,
    output logic [`MEM_IDX_W-1:0]      wr_idx,
    output mem_stage_pkg::byte_en_t    wr_be,
    output mem_stage_pkg::word_t       wr_data
);

    logic [1:0]           off;
    mem_stage_pkg::word_t src;

    assign off = sel_access.addr[1:0];
    assign src = sel_access.wdata;

    assign wr_en  = sel_access.valid & sel_access.is_store;
    assign wr_idx = sel_access.addr[`MEM_IDX_W+1:2];  // word index above the offset

    always_comb begin
        wr_be   = 4'b0000;
        wr_data = src;
        case (sel_access.op)
            `OP_SW, `OP_SC: begin
                wr_be   = 4'b1111;
                wr_data = src;
            end
            `OP_SH: begin
                wr_be   = off[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{src[15:0]}};
            end
            `OP_SB: begin
                wr_be   = 4'b0001 << off;
                wr_data = {4{src[7:0]}};
            end
            // top bytes of rt into the low lanes
            `OP_SWL: begin
                wr_be   = 4'b1111 >> (~off);
                wr_data = src >> {~off, 3'b000};
            end
            // low bytes of rt into the high lanes
            `OP_SWR: begin
                wr_be   = 4'b1111 << off;
                wr_data = src << {off, 3'b000};
            end
            default: begin
                wr_be   = 4'b0000;
                wr_data = src;
            end
        endcase
    end

endmodule

//--- hdl/access_check.sv
`timescale 1ns/1ps
`include "mem_stage_consts.svh"

module access_check (
    input  mem_stage_pkg::mem_req_t    req0,
    input  mem_stage_pkg::mem_req_t    req1,
    input  logic                       mem_sel,
    output mem_stage_pkg::mem_exc_t    exc0,
    output mem_stage_pkg::mem_exc_t    exc1,
    output mem_stage_pkg::mem_access_t sel_access
);

    mem_stage_pkg::mem_req_t sel_req;
    mem_stage_pkg::mem_exc_t sel_exc;
    logic                    sel_ld;
    logic                    sel_st;

    function automatic logic op_is_load(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU,
            `OP_LW, `OP_LWL, `OP_LWR, `OP_LL: op_is_load = 1'b1;
            default:                          op_is_load = 1'b0;
        endcase
    endfunction

    function automatic logic op_is_store(input mem_stage_pkg::opcode_t op);
        case (op)
            `OP_SB, `OP_SH, `OP_SW, `OP_SWL, `OP_SWR, `OP_SC: op_is_store = 1'b1;
            default:                                          op_is_store = 1'b0;
        endcase
    endfunction

    // byte ops and lwl/lwr/swl/swr never fault
    function automatic logic misaligned(input mem_stage_pkg::opcode_t op,
                                        input logic [1:0]           off);
        case (op)
            `OP_LW, `OP_LL, `OP_SW, `OP_SC: misaligned = (off != 2'b00);
            `OP_LH, `OP_LHU, `OP_SH:        misaligned = off[0];
            default:                        misaligned = 1'b0;
        endcase
    endfunction

    // both lanes are checked, selected or not
    assign exc0.load_err  = req0.valid & op_is_load(req0.op) & misaligned(req0.op, req0.addr[1:0]);
    assign exc0.store_err = req0.valid & op_is_store(req0.op) & misaligned(req0.op, req0.addr[1:0]);
    assign exc1.load_err  = req1.valid & op_is_load(req1.op) & misaligned(req1.op, req1.addr[1:0]);
    assign exc1.store_err = req1.valid & op_is_store(req1.op) & misaligned(req1.op, req1.addr[1:0]);

    assign sel_req = mem_sel ? req0 : req1;  // high picks lane 0
    assign sel_exc = mem_sel ? exc0 : exc1;
    assign sel_ld  = op_is_load(sel_req.op);
    assign sel_st  = op_is_store(sel_req.op);

    assign sel_access.valid    = sel_req.valid & (sel_ld | sel_st)
                               & ~(sel_exc.load_err | sel_exc.store_err);
    assign sel_access.op       = sel_req.op;
    assign sel_access.addr     = sel_req.addr;
    assign sel_access.wdata    = sel_req.wdata;
    assign sel_access.rt_value = sel_req.rt_value;
    assign sel_access.is_load  = sel_ld;
    assign sel_access.is_store = sel_st;

endmodule

//--- hdl/mem_stage_pkg.sv
`include "mem_stage_consts.svh"

package mem_stage_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [31:0]        addr_t;     // byte address
    typedef logic [5:0]         opcode_t;
    typedef logic [3:0]         byte_en_t;  // bit 0 = byte 0

    // one lane's request in M
    typedef struct packed {
        logic    valid;
        opcode_t op;
        addr_t   addr;
        word_t   wdata;     // store source
        word_t   rt_value;  // old rt, merged by lwl/lwr
    } mem_req_t;

    typedef struct packed {
        logic load_err;
        logic store_err;
    } mem_exc_t;

    // access that owns the memory port this cycle
    typedef struct packed {
        logic    valid;
        opcode_t op;
        addr_t   addr;
        word_t   wdata;
        word_t   rt_value;
        logic    is_load;
        logic    is_store;
    } mem_access_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } load_resp_t;

endpackage

//--- hdl/mem_stage_consts.svh
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// MIPS primary opcodes, bits 31:26 of the instruction
`define OP_LB   6'h20
`define OP_LH   6'h21
`define OP_LWL  6'h22
`define OP_LW   6'h23
`define OP_LBU  6'h24
`define OP_LHU  6'h25
`define OP_LWR  6'h26

`define OP_SB   6'h28
`define OP_SH   6'h29
`define OP_SWL  6'h2a
`define OP_SW   6'h2b
`define OP_SWR  6'h2e

// LL/SC behave as LW/SW here
`define OP_LL   6'h30
`define OP_SC   6'h38

// datapath width
`define DATA_W  32

// data ram geometry, in words
`define MEM_DEPTH_WORDS 256
`define MEM_IDX_W       8

`endif
